//--- list.f
src/replay_pkg.sv
src/replay_regs.sv
src/pkt_capture.sv
src/pkt_buffer.sv
src/replay_engine.sv
src/pcap_replay_top.sv
verif/replay_properties.sv
verif/tb_pcap_replay.sv

//--- verif/tb_pcap_replay.sv
// Testbench for the packet capture and replay engine
// Captures random packets, replays them with and without back-pressure,
// and checks every output beat against a model of the captured words

`timescale 1ns/1ns

module tb_pcap_replay import replay_pkg::*; ();

  localparam int EXPECTED_BEATS = 36 + 36 + 36 + 16;
  localparam int TIMEOUT_CYCLES = 40 * EXPECTED_BEATS + 2000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              reg_wr;
  logic              reg_rd;
  reg_addr_t         reg_addr;
  logic [REG_W-1:0]  reg_wdata;
  logic [REG_W-1:0]  reg_rdata;
  logic              reg_rvalid;
  logic [DATA_W-1:0] s_axis_tdata;
  logic              s_axis_tvalid;
  logic              s_axis_tlast;
  logic              s_axis_tready;
  logic [DATA_W-1:0] m_axis_tdata;
  logic              m_axis_tvalid;
  logic              m_axis_tlast;
  logic              m_axis_tready;

  logic [31:0]       lfsr_q = 32'h54d2892b;
  logic [DATA_W-1:0] model_data [BUF_DEPTH];
  logic              model_last [BUF_DEPTH];
  int                exp_high;
  int                exp_total;
  int                out_count;
  int                cycle_count;
  int                mismatches;
  int                other_errors;
  logic              bp_mode;
  buf_word_t         exp_word;
  logic [REG_W-1:0]  rd_val;

  pcap_replay_top dut_i (.*, .axi_aclk(clk));

  always #2 clk = ~clk;

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        lsb;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb) lfsr_q = lfsr_q ^ 32'h80200003;
      v = {v[62:0], lsb};
    end
    return v;
  endfunction

  // Beat k of the replay is captured word k modulo the pass length
  function automatic buf_word_t expected_beat(input int k);
    int idx;
    idx = k % (exp_high + 1);
    return '{data: model_data[idx], last: model_last[idx]};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp, act);
    $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    mismatches++;
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [REG_W-1:0] data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  // Read data is due exactly one cycle after the strobe
  task automatic read_reg(input reg_addr_t addr, output logic [REG_W-1:0] data);
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_rd = 1'b0;
    if (reg_rvalid !== 1'b1) begin
      $display("reg_rvalid not high one cycle after the read strobe at time %0t", $time);
      other_errors++;
    end
    data = reg_rdata;
  endtask

  task automatic send_beat(input int idx, input logic [DATA_W-1:0] d, input logic last);
    @(negedge clk);
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = d;
    s_axis_tlast  = last;
    while (!s_axis_tready) @(negedge clk);
    model_data[idx] = d;
    model_last[idx] = last;
  endtask

  // Packets of 1 to 4 words until the total is reached
  task automatic capture_packets(input int total);
    int remaining;
    int plen;
    int idx;
    int j;
    remaining = total;
    idx = 0;
    while (remaining > 0) begin
      plen = int'(take_bits(2)) + 1;
      if (plen > remaining) plen = remaining;
      for (j = 0; j < plen; j++) begin
        send_beat(idx, take_bits(DATA_W), j == plen - 1);
        idx++;
      end
      remaining -= plen;
    end
    @(negedge clk);
    s_axis_tvalid = 1'b0;
  endtask

  task automatic run_replay(input int count, input int high, input logic bp);
    logic [REG_W-1:0] st;
    out_count = 0;
    exp_high  = high;
    exp_total = count * (high + 1);
    bp_mode   = bp;
    write_reg(REG_COUNT, count);
    write_reg(REG_CTRL, 32'h2);
    while (out_count < exp_total) @(negedge clk);
    bp_mode = 1'b0;
    read_reg(REG_STATUS, st);
    if (st[15] !== 1'b0) report_mismatch("status.busy", 0, st[15]);
    if (st[31:16] !== count) report_mismatch("status.passes_done", count, st[31:16]);
  endtask

  // Sink ready is random under back-pressure tests
  always @(negedge clk) begin
    if (bp_mode) begin
      m_axis_tready = take_bits(1) != 0;
    end else begin
      m_axis_tready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (rst_n && m_axis_tvalid && m_axis_tready) begin
      if (out_count >= exp_total) begin
        $display("Unexpected extra beat on m_axis at time %0t", $time);
        other_errors++;
      end else begin
        exp_word = expected_beat(out_count);
        if (m_axis_tdata !== exp_word.data)
          report_mismatch("m_axis_tdata", exp_word.data, m_axis_tdata);
        if (m_axis_tlast !== exp_word.last)
          report_mismatch("m_axis_tlast", exp_word.last, m_axis_tlast);
      end
      out_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d replay beats received",
               cycle_count, out_count, exp_total);
      other_errors++;
      $display("mismatches=%0d other_errors=%0d assertion_failures=%0d",
               mismatches, other_errors, dut_i.props_i.assert_fails);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = REG_CTRL;
    reg_wdata = '0;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    m_axis_tready = 1'b1;
    bp_mode = 1'b0;
    exp_high = 0;
    exp_total = 0;
    out_count = 0;
    cycle_count = 0;
    mismatches = 0;
    other_errors = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Register access and the start bit reading back as 0
    write_reg(REG_ADDR_HIGH, 32'ha5);
    read_reg(REG_ADDR_HIGH, rd_val);
    if (rd_val !== 32'ha5) report_mismatch("reg_rdata", 32'ha5, rd_val);
    write_reg(REG_COUNT, 32'h1234);
    read_reg(REG_COUNT, rd_val);
    if (rd_val !== 32'h1234) report_mismatch("reg_rdata", 32'h1234, rd_val);
    write_reg(REG_CTRL, 32'h2);
    read_reg(REG_CTRL, rd_val);
    if (rd_val !== 32'h0) report_mismatch("reg_rdata", 0, rd_val);

    // Capture fills to mem_addr_high + 1 words
    write_reg(REG_ADDR_HIGH, 32'd11);
    capture_packets(12);
    if (s_axis_tready !== 1'b0) report_mismatch("s_axis_tready", 0, s_axis_tready);
    read_reg(REG_STATUS, rd_val);
    if (rd_val[8:0] !== 9'd12) report_mismatch("status.capture_count", 12, rd_val[8:0]);

    run_replay(3, 11, 1'b0);
    run_replay(3, 11, 1'b1);

    // Zero replays sends nothing
    out_count = 0;
    exp_total = 0;
    write_reg(REG_COUNT, 32'd0);
    write_reg(REG_CTRL, 32'h2);
    repeat (20) @(negedge clk);
    read_reg(REG_STATUS, rd_val);
    if (rd_val[15] !== 1'b0) report_mismatch("status.busy", 0, rd_val[15]);

    // Abort a replay with sw_rst
    out_count = 0;
    exp_total = 36;
    write_reg(REG_COUNT, 32'd3);
    write_reg(REG_CTRL, 32'h2);
    while (out_count < 10) @(negedge clk);
    write_reg(REG_CTRL, 32'h1);
    @(negedge clk);
    exp_total = 0;
    repeat (3) begin
      if (m_axis_tvalid !== 1'b0) report_mismatch("m_axis_tvalid", 0, m_axis_tvalid);
      @(negedge clk);
    end
    read_reg(REG_STATUS, rd_val);
    if (rd_val[8:0] !== 9'd0) report_mismatch("status.capture_count", 0, rd_val[8:0]);
    if (rd_val[15] !== 1'b0) report_mismatch("status.busy", 0, rd_val[15]);

    // Fresh capture and replay after sw_rst is cleared
    write_reg(REG_CTRL, 32'h0);
    write_reg(REG_ADDR_HIGH, 32'd7);
    capture_packets(8);
    run_replay(2, 7, 1'b1);

    repeat (10) @(negedge clk);
    $display("mismatches=%0d other_errors=%0d assertion_failures=%0d",
             mismatches, other_errors, dut_i.props_i.assert_fails);
    if (mismatches == 0 && other_errors == 0 && dut_i.props_i.assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verif/replay_properties.sv
// Stream and capture checks for the packet capture and replay engine
// Bound to the top level stream and capture ports

`timescale 1ns/1ns

module replay_properties import replay_pkg::*; (
  input logic              axi_aclk,
  input logic              rst_n,
  input logic              sw_rst,
  input logic              s_axis_tready,
  input logic              m_axis_tvalid,
  input logic              m_axis_tready,
  input logic              m_axis_tlast,
  input logic [DATA_W-1:0] m_axis_tdata
);

  int assert_fails = 0;

  // A held beat must not change until the sink takes it
  a_hold_stable: assert property (@(posedge axi_aclk) disable iff (!rst_n || sw_rst)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    else begin
      $error("m_axis beat changed while stalled");
      assert_fails++;
    end

  // Capture stays closed while replay output is pending
  a_no_capture_on_replay: assert property (@(posedge axi_aclk) disable iff (!rst_n)
    m_axis_tvalid |-> !s_axis_tready)
    else begin
      $error("s_axis_tready high with an m_axis beat pending");
      assert_fails++;
    end

  a_reset_clears_valid: assert property (@(posedge axi_aclk)
    !rst_n |=> !m_axis_tvalid)
    else begin
      $error("m_axis_tvalid high after reset");
      assert_fails++;
    end

endmodule

bind pcap_replay_top replay_properties props_i (
  .axi_aclk      (axi_aclk),
  .rst_n         (rst_n),
  .sw_rst        (ctrl.sw_rst),
  .s_axis_tready (s_axis_tready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tdata  (m_axis_tdata)
);

//--- src/pcap_replay_top.sv
// Packet capture and replay top level
// Register file, capture block, packet buffer and replay engine

`timescale 1ns/1ns

module pcap_replay_top import replay_pkg::*; (
  input  logic              axi_aclk,
  input  logic              rst_n,

  // Register port
  input  logic              reg_wr,
  input  logic              reg_rd,
  input  reg_addr_t         reg_addr,
  input  logic [REG_W-1:0]  reg_wdata,
  output logic [REG_W-1:0]  reg_rdata,
  output logic              reg_rvalid,

  // Slave stream, capture side
  input  logic [DATA_W-1:0] s_axis_tdata,
  input  logic              s_axis_tvalid,
  input  logic              s_axis_tlast,
  output logic              s_axis_tready,

  // Master stream, replay side
  output logic [DATA_W-1:0] m_axis_tdata,
  output logic              m_axis_tvalid,
  output logic              m_axis_tlast,
  input  logic              m_axis_tready
);

  replay_ctrl_t          ctrl;
  replay_status_t        status;
  logic                  wr_en;
  logic [BUF_ADDR_W-1:0] wr_addr;
  buf_word_t             wr_word;
  logic                  rd_en;
  logic [BUF_ADDR_W-1:0] rd_addr;
  buf_word_t             rd_word;
  logic                  busy;
  logic [BUF_ADDR_W:0]   capture_count;
  logic [COUNT_W-1:0]    passes_done;

  assign status = '{busy: busy, capture_count: capture_count, passes_done: passes_done};

  replay_regs regs_i (
    .axi_aclk   (axi_aclk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .status     (status),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .ctrl       (ctrl)
  );

  pkt_capture capture_i (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .busy          (busy),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_word       (wr_word),
    .capture_count (capture_count)
  );

  pkt_buffer buffer_i (
    .axi_aclk (axi_aclk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_word  (wr_word),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word)
  );

  replay_engine engine_i (
    .axi_aclk      (axi_aclk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .capture_count (capture_count),
    .rd_word       (rd_word),
    .m_axis_tready (m_axis_tready),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .busy          (busy),
    .passes_done   (passes_done)
  );

endmodule

//--- src/replay_engine.sv
// Replay engine
// Streams buffer words 0 to mem_addr_high out on the master stream,
// repeating the pass replay_count times and stalling on back-pressure

`timescale 1ns/1ns

module replay_engine import replay_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  rst_n,
  input  replay_ctrl_t          ctrl,
  input  logic [BUF_ADDR_W:0]   capture_count,
  input  buf_word_t             rd_word,
  input  logic                  m_axis_tready,
  output logic                  rd_en,
  output logic [BUF_ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0]     m_axis_tdata,
  output logic                  m_axis_tlast,
  output logic                  m_axis_tvalid,
  output logic                  busy,
  output logic [COUNT_W-1:0]    passes_done
);

  replay_state_t         state_q;
  logic [BUF_ADDR_W-1:0] addr_q;
  logic [COUNT_W-1:0]    passes_q;
  logic                  out_valid_q;
  logic                  can_accept;
  logic                  issue;
  logic                  pass_end;
  logic                  last_pass;
  logic                  start_ok;

  // RAM output register is the output stage
  assign can_accept = !out_valid_q || m_axis_tready;
  assign issue      = (state_q == ST_RUN) && can_accept;
  assign pass_end   = addr_q == ctrl.mem_addr_high;
  assign last_pass  = COUNT_W'(passes_q + 1'b1) == ctrl.replay_count;

  // Nothing to send when either count is zero
  assign start_ok = ctrl.start_replay && (ctrl.replay_count != '0) &&
                    (capture_count != '0);

  always_ff @(posedge axi_aclk) begin
    if (!rst_n || ctrl.sw_rst) begin
      state_q  <= ST_IDLE;
      addr_q   <= '0;
      passes_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_ok) begin
            state_q  <= ST_RUN;
            addr_q   <= '0;
            passes_q <= '0;
          end
        end
        ST_RUN: begin
          if (issue) begin
            if (pass_end) begin
              addr_q   <= '0;
              passes_q <= passes_q + 1'b1;
              if (last_pass) begin
                state_q <= ST_WAIT_LAST;
              end
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        ST_WAIT_LAST: begin
          // Final word already sits in the output stage
          if (out_valid_q && m_axis_tready) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Output stage occupancy
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || ctrl.sw_rst) begin
      out_valid_q <= 1'b0;
    end else if (can_accept) begin
      out_valid_q <= issue;
    end
  end

  assign rd_en         = issue;
  assign rd_addr       = addr_q;
  assign m_axis_tdata  = rd_word.data;
  assign m_axis_tlast  = rd_word.last;
  assign m_axis_tvalid = out_valid_q;
  assign busy          = state_q != ST_IDLE;
  assign passes_done   = passes_q;

endmodule

//--- src/pkt_buffer.sv
// Packet buffer
// Single clock RAM, one write port and a registered read port with enable

`timescale 1ns/1ns

module pkt_buffer import replay_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  wr_en,
  input  logic [BUF_ADDR_W-1:0] wr_addr,
  input  buf_word_t             wr_word,
  input  logic                  rd_en,
  input  logic [BUF_ADDR_W-1:0] rd_addr,
  output buf_word_t             rd_word
);

  buf_word_t mem [BUF_DEPTH];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // Output register doubles as the replay output stage
  // and holds its word while rd_en is low
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

endmodule

//--- src/pkt_capture.sv
// Packet capture
// Writes accepted slave stream beats into the buffer from address 0 upward

`timescale 1ns/1ns

module pkt_capture import replay_pkg::*; (
  input  logic                  axi_aclk,
  input  logic                  rst_n,
  input  replay_ctrl_t          ctrl,
  input  logic                  busy,
  input  logic [DATA_W-1:0]     s_axis_tdata,
  input  logic                  s_axis_tvalid,
  input  logic                  s_axis_tlast,
  output logic                  s_axis_tready,
  output logic                  wr_en,
  output logic [BUF_ADDR_W-1:0] wr_addr,
  output buf_word_t             wr_word,
  output logic [BUF_ADDR_W:0]   capture_count
);

  logic active_q;
  logic has_room;

  // Comes up the cycle after reset is released
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  assign has_room      = capture_count <= {1'b0, ctrl.mem_addr_high};
  assign s_axis_tready = active_q && !ctrl.sw_rst && !busy && has_room;

  assign wr_en   = s_axis_tvalid && s_axis_tready;
  assign wr_addr = capture_count[BUF_ADDR_W-1:0];
  assign wr_word = '{data: s_axis_tdata, last: s_axis_tlast};

  // Fill level, also the next write address
  always_ff @(posedge axi_aclk) begin
    if (!rst_n || ctrl.sw_rst) begin
      capture_count <= '0;
    end else if (wr_en) begin
      capture_count <= capture_count + 1'b1;
    end
  end

endmodule

//--- src/replay_regs.sv
// Register file for the capture and replay engine
// Control word, last buffer address, replay count and read-only status

`timescale 1ns/1ns

module replay_regs import replay_pkg::*; (
  input  logic           axi_aclk,
  input  logic           rst_n,
  input  logic           reg_wr,
  input  logic           reg_rd,
  input  reg_addr_t      reg_addr,
  input  logic [REG_W-1:0] reg_wdata,
  input  replay_status_t status,
  output logic [REG_W-1:0] reg_rdata,
  output logic           reg_rvalid,
  output replay_ctrl_t   ctrl
);

  logic                  sw_rst_q;
  logic                  start_q;
  logic [BUF_ADDR_W-1:0] addr_high_q;
  logic [COUNT_W-1:0]    count_q;

  // Writes land on the sampling edge
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      sw_rst_q    <= 1'b0;
      start_q     <= 1'b0;
      addr_high_q <= '0;
      count_q     <= '0;
    end else begin
      // Start bit is a one-cycle pulse and never stored
      start_q <= reg_wr && (reg_addr == REG_CTRL) && reg_wdata[1];
      if (reg_wr) begin
        case (reg_addr)
          REG_CTRL:      sw_rst_q    <= reg_wdata[0];
          REG_ADDR_HIGH: addr_high_q <= reg_wdata[BUF_ADDR_W-1:0];
          REG_COUNT:     count_q     <= reg_wdata[COUNT_W-1:0];
          default:       ;
        endcase
      end
    end
  end

  // Read data returned one cycle after the strobe
  always_ff @(posedge axi_aclk) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
      reg_rdata  <= '0;
    end else begin
      reg_rvalid <= reg_rd;
      if (reg_rd) begin
        case (reg_addr)
          REG_CTRL:      reg_rdata <= {{(REG_W-1){1'b0}}, sw_rst_q};
          REG_ADDR_HIGH: reg_rdata <= {{(REG_W-BUF_ADDR_W){1'b0}}, addr_high_q};
          REG_COUNT:     reg_rdata <= {{(REG_W-COUNT_W){1'b0}}, count_q};
          default:       reg_rdata <= {status.passes_done, status.busy, 6'b0,
                                       status.capture_count};
        endcase
      end
    end
  end

  assign ctrl = '{sw_rst: sw_rst_q, start_replay: start_q,
                  mem_addr_high: addr_high_q, replay_count: count_q};

endmodule

//--- src/replay_pkg.sv
// Packet capture and replay engine shared definitions
// Widths, register map, engine states and the structs passed between blocks

package replay_pkg;

  localparam int DATA_W     = 64;
  localparam int BUF_ADDR_W = 8;
  localparam int BUF_DEPTH  = 1 << BUF_ADDR_W;
  localparam int COUNT_W    = 16;
  localparam int REG_W      = 32;

  // Register map, word addressed
  typedef enum logic [1:0] {
    REG_CTRL      = 2'd0,
    REG_ADDR_HIGH = 2'd1,
    REG_COUNT     = 2'd2,
    REG_STATUS    = 2'd3
  } reg_addr_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_WAIT_LAST
  } replay_state_t;

  // One buffer entry, a stream beat with its end of packet flag
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } buf_word_t;

  typedef struct packed {
    logic                  sw_rst;
    logic                  start_replay;
    logic [BUF_ADDR_W-1:0] mem_addr_high;
    logic [COUNT_W-1:0]    replay_count;
  } replay_ctrl_t;

  typedef struct packed {
    logic                busy;
    logic [BUF_ADDR_W:0] capture_count;
    logic [COUNT_W-1:0]  passes_done;
  } replay_status_t;

endpackage
